//--- verilog/dpPkg.sv
package dpPkg;

  // ============================================================
  // Datapath widths
  // ============================================================
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 4;
  localparam int numRegs      = 16;
  localparam int flagWidth    = 4;

  // Flag vector positions, N Z C V from high to low
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // ============================================================
  // Instruction word fields
  // ============================================================
  localparam int opLsb      = 28;
  localparam int immBit     = 27;
  localparam int rdLsb      = 23;
  localparam int rnLsb      = 19;
  localparam int rmLsb      = 15;
  localparam int shTypeLsb  = 13;
  localparam int shAmtLsb   = 8;
  localparam int shAmtWidth = 5;
  localparam int imm8Lsb    = 0;
  localparam int imm8Width  = 8;

  // Opcode in bits 31:28
  typedef enum logic [3:0] {
    opAnd = 4'd0,
    opEor = 4'd1,
    opSub = 4'd2,
    opAdd = 4'd3,
    opOrr = 4'd4,
    opMov = 4'd5,
    opMvn = 4'd6,
    opCmp = 4'd7
  } aluOpE;

  // Shift type in bits 14:13
  typedef enum logic [1:0] {
    shLsl = 2'd0,
    shLsr = 2'd1,
    shAsr = 2'd2,
    shRor = 2'd3
  } shiftOpE;

endpackage

//--- verilog/regFile.sv
`timescale 1ns/100ps

module regFile (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic [dpPkg::regAddrWidth-1:0] rdAddrA,
  input  logic [dpPkg::regAddrWidth-1:0] rdAddrB,
  output logic [dpPkg::dataWidth-1:0]    rdDataA,
  output logic [dpPkg::dataWidth-1:0]    rdDataB,
  input  logic                           wrEn,
  input  logic [dpPkg::regAddrWidth-1:0] wrAddr,
  input  logic [dpPkg::dataWidth-1:0]    wrData
);
  import dpPkg::*;

  // Sixteen general registers
  logic [dataWidth-1:0] regs [numRegs];

  // Hit flags for the write-through bypass
  logic hitA;
  logic hitB;

  // All registers read as zero after reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // A read of the register being written sees the new value
  assign hitA = wrEn && (wrAddr == rdAddrA);
  assign hitB = wrEn && (wrAddr == rdAddrB);

  // Combinational read ports
  assign rdDataA = hitA ? wrData : regs[rdAddrA];
  assign rdDataB = hitB ? wrData : regs[rdAddrB];

endmodule

//--- verilog/barrelShifter.sv
`timescale 1ns/100ps

module barrelShifter (
  input  logic [dpPkg::dataWidth-1:0]  value,
  input  dpPkg::shiftOpE               shiftOp,
  input  logic [dpPkg::shAmtWidth-1:0] shAmt,
  input  logic                         carryIn,
  output logic [dpPkg::dataWidth-1:0]  result,
  output logic                         carryOut
);
  import dpPkg::*;

  // Extra bit on the left catches the last bit shifted out of LSL
  logic [dataWidth:0]     lslWide;
  // Extra bit on the right catches the last bit shifted out of LSR and ASR
  logic [dataWidth:0]     lsrWide;
  logic [dataWidth:0]     asrWide;
  // Doubled word, low half of the shift is the rotation
  logic [2*dataWidth-1:0] rorWide;

  assign lslWide = {1'b0, value} << shAmt;
  assign lsrWide = {value, 1'b0} >> shAmt;
  // Sign of the padded word is the value sign bit
  assign asrWide = $signed({value, 1'b0}) >>> shAmt;
  assign rorWide = {value, value} >> shAmt;

  always_comb begin
    result   = value;
    carryOut = carryIn;
    // Zero amount passes value and carry unchanged
    if (shAmt != '0) begin
      case (shiftOp)
        shLsl: begin
          result   = lslWide[dataWidth-1:0];
          carryOut = lslWide[dataWidth];
        end
        shLsr: begin
          result   = lsrWide[dataWidth:1];
          carryOut = lsrWide[0];
        end
        shAsr: begin
          result   = asrWide[dataWidth:1];
          carryOut = asrWide[0];
        end
        default: begin
          // ROR, carry is the new top bit
          result   = rorWide[dataWidth-1:0];
          carryOut = rorWide[dataWidth-1];
        end
      endcase
    end
  end

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           stall,
  input  logic                           instrValid,
  input  logic [dpPkg::dataWidth-1:0]    instr,
  output logic                           instrReady,
  output logic [dpPkg::regAddrWidth-1:0] rnAddr,
  output logic [dpPkg::regAddrWidth-1:0] rmAddr,
  input  logic [dpPkg::dataWidth-1:0]    rnData,
  input  logic [dpPkg::dataWidth-1:0]    rmData,
  output logic                           dValid,
  output dpPkg::aluOpE                   aluOp,
  output dpPkg::shiftOpE                 shiftOp,
  output logic [dpPkg::shAmtWidth-1:0]   shAmt,
  output logic                           useImm,
  output logic [dpPkg::imm8Width-1:0]    imm8,
  output logic [dpPkg::regAddrWidth-1:0] rd,
  output logic [dpPkg::dataWidth-1:0]    rnOut,
  output logic [dpPkg::dataWidth-1:0]    rmOut,
  output logic [dpPkg::regAddrWidth-1:0] rnIdx,
  output logic [dpPkg::regAddrWidth-1:0] rmIdx
);
  import dpPkg::*;

  logic                 accept;
  logic                 dValidQ;
  // D register, holds the word being decoded
  logic [dataWidth-1:0] instrQ;

  // ============================================================
  // Input handshake
  // ============================================================
  // Ready unless retire is backed up
  assign instrReady = !stall;
  assign accept     = instrValid && instrReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      dValidQ <= 1'b0;
    end else if (!stall) begin
      // Bubble when nothing is offered
      dValidQ <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      instrQ <= instr;
    end
  end

  assign dValid = dValidQ;

  // ============================================================
  // Field decode
  // ============================================================
  assign aluOp   = aluOpE'(instrQ[opLsb +: $bits(aluOpE)]);
  assign shiftOp = shiftOpE'(instrQ[shTypeLsb +: $bits(shiftOpE)]);
  assign shAmt   = instrQ[shAmtLsb +: shAmtWidth];
  assign useImm  = instrQ[immBit];
  assign imm8    = instrQ[imm8Lsb +: imm8Width];
  assign rd      = instrQ[rdLsb +: regAddrWidth];

  // Register file addressed straight from the D register
  assign rnAddr = instrQ[rnLsb +: regAddrWidth];
  assign rmAddr = instrQ[rmLsb +: regAddrWidth];

  // Operands and their indices, indices feed forwarding in execute
  assign rnOut = rnData;
  assign rmOut = rmData;
  assign rnIdx = rnAddr;
  assign rmIdx = rmAddr;

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/100ps

module executeStage (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           stall,
  input  logic                           dValid,
  input  dpPkg::aluOpE                   aluOp,
  input  dpPkg::shiftOpE                 shiftOp,
  input  logic [dpPkg::shAmtWidth-1:0]   shAmt,
  input  logic                           useImm,
  input  logic [dpPkg::imm8Width-1:0]    imm8,
  input  logic [dpPkg::regAddrWidth-1:0] rd,
  input  logic [dpPkg::dataWidth-1:0]    rnOut,
  input  logic [dpPkg::dataWidth-1:0]    rmOut,
  input  logic [dpPkg::regAddrWidth-1:0] rnIdx,
  input  logic [dpPkg::regAddrWidth-1:0] rmIdx,
  input  logic                           retireValid,
  input  logic                           retireWrite,
  input  logic [dpPkg::regAddrWidth-1:0] retireReg,
  input  logic [dpPkg::dataWidth-1:0]    retireData,
  output logic                           eValid,
  output logic                           eWrite,
  output logic [dpPkg::regAddrWidth-1:0] eReg,
  output logic [dpPkg::dataWidth-1:0]    eData,
  output logic [dpPkg::flagWidth-1:0]    eFlags
);
  import dpPkg::*;

  // E register
  logic                    eValidQ;
  aluOpE                   aluOpQ;
  shiftOpE                 shiftOpQ;
  logic [shAmtWidth-1:0]   shAmtQ;
  logic                    useImmQ;
  logic [imm8Width-1:0]    imm8Q;
  logic [regAddrWidth-1:0] rdQ;
  logic [dataWidth-1:0]    rnQ;
  logic [dataWidth-1:0]    rmQ;
  logic [regAddrWidth-1:0] rnIdxQ;
  logic [regAddrWidth-1:0] rmIdxQ;
  // Current NZCV
  logic [flagWidth-1:0]    flagsQ;

  logic                    fwdA;
  logic                    fwdB;
  logic [dataWidth-1:0]    opA;
  logic [dataWidth-1:0]    rmFwd;
  logic [dataWidth-1:0]    shiftedRm;
  logic                    shCarry;
  logic [dataWidth-1:0]    op2;
  logic                    op2Carry;
  logic                    isSub;
  logic                    isArith;
  logic [dataWidth-1:0]    addB;
  logic [dataWidth-1:0]    addSum;
  logic                    addCarry;
  logic                    addOvf;
  logic [dataWidth-1:0]    aluResult;
  logic [flagWidth-1:0]    newFlags;

  // ============================================================
  // E register, frozen under back-pressure
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      eValidQ <= 1'b0;
    end else if (!stall) begin
      eValidQ <= dValid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      aluOpQ   <= aluOp;
      shiftOpQ <= shiftOp;
      shAmtQ   <= shAmt;
      useImmQ  <= useImm;
      imm8Q    <= imm8;
      rdQ      <= rd;
      rnQ      <= rnOut;
      rmQ      <= rmOut;
      rnIdxQ   <= rnIdx;
      rmIdxQ   <= rmIdx;
    end
  end

  // ============================================================
  // Forwarding and operand select
  // ============================================================
  // Retire holds the instruction directly ahead
  assign fwdA  = retireValid && retireWrite && (retireReg == rnIdxQ);
  assign fwdB  = retireValid && retireWrite && (retireReg == rmIdxQ);
  assign opA   = fwdA ? retireData : rnQ;
  assign rmFwd = fwdB ? retireData : rmQ;

  barrelShifter shifter (
    .value    (rmFwd),
    .shiftOp  (shiftOpQ),
    .shAmt    (shAmtQ),
    .carryIn  (flagsQ[flagC]),
    .result   (shiftedRm),
    .carryOut (shCarry)
  );

  // Immediate is zero-extended and keeps the current carry
  assign op2      = useImmQ ? {{(dataWidth-imm8Width){1'b0}}, imm8Q} : shiftedRm;
  assign op2Carry = useImmQ ? flagsQ[flagC] : shCarry;

  // ============================================================
  // ALU
  // ============================================================
  assign isSub   = (aluOpQ == opSub) || (aluOpQ == opCmp);
  assign isArith = isSub || (aluOpQ == opAdd);
  // Subtract as A + ~B + 1, carry set means no borrow
  assign addB    = isSub ? ~op2 : op2;
  assign {addCarry, addSum} = {1'b0, opA} + {1'b0, addB} + {{dataWidth{1'b0}}, isSub};
  assign addOvf  = (opA[dataWidth-1] == addB[dataWidth-1]) &&
                   (addSum[dataWidth-1] != opA[dataWidth-1]);

  always_comb begin
    case (aluOpQ)
      opAnd:        aluResult = opA & op2;
      opEor:        aluResult = opA ^ op2;
      opSub, opAdd: aluResult = addSum;
      opOrr:        aluResult = opA | op2;
      opMov:        aluResult = op2;
      opMvn:        aluResult = ~op2;
      opCmp:        aluResult = addSum;
      default:      aluResult = '0;
    endcase
  end

  // Logical ops take shifter carry and keep V
  always_comb begin
    newFlags[flagN] = aluResult[dataWidth-1];
    newFlags[flagZ] = (aluResult == '0);
    newFlags[flagC] = isArith ? addCarry : op2Carry;
    newFlags[flagV] = isArith ? addOvf : flagsQ[flagV];
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (!stall && eValidQ) begin
      flagsQ <= newFlags;
    end
  end

  // Toward retire
  assign eValid = eValidQ;
  assign eWrite = (aluOpQ != opCmp);
  assign eReg   = rdQ;
  assign eData  = aluResult;
  assign eFlags = newFlags;

endmodule

//--- verilog/retireStage.sv
`timescale 1ns/100ps

module retireStage (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           eValid,
  input  logic                           eWrite,
  input  logic [dpPkg::regAddrWidth-1:0] eReg,
  input  logic [dpPkg::dataWidth-1:0]    eData,
  input  logic [dpPkg::flagWidth-1:0]    eFlags,
  input  logic                           retireReady,
  output logic                           retireValid,
  output logic                           retireWrite,
  output logic [dpPkg::regAddrWidth-1:0] retireReg,
  output logic [dpPkg::dataWidth-1:0]    retireData,
  output logic [dpPkg::flagWidth-1:0]    retireFlags,
  output logic                           stall,
  output logic                           wrEn,
  output logic [dpPkg::regAddrWidth-1:0] wrAddr,
  output logic [dpPkg::dataWidth-1:0]    wrData
);
  import dpPkg::*;

  // Retire result register
  logic                    validQ;
  logic                    writeQ;
  logic [regAddrWidth-1:0] regQ;
  logic [dataWidth-1:0]    dataQ;
  logic [flagWidth-1:0]    flagsQ;

  // Held result not taken, freeze everything upstream
  assign stall = validQ && !retireReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else if (!stall) begin
      validQ <= eValid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && eValid) begin
      writeQ <= eWrite;
      regQ   <= eReg;
      dataQ  <= eData;
      flagsQ <= eFlags;
    end
  end

  assign retireValid = validQ;
  assign retireWrite = writeQ;
  assign retireReg   = regQ;
  assign retireData  = dataQ;
  assign retireFlags = flagsQ;

  // One write per writing instruction, on the handshake
  assign wrEn   = validQ && retireReady && writeQ;
  assign wrAddr = regQ;
  assign wrData = dataQ;

endmodule

//--- verilog/datapathTop.sv
`timescale 1ns/100ps

module datapathTop (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           instrValid,
  input  logic [dpPkg::dataWidth-1:0]    instr,
  output logic                           instrReady,
  output logic                           retireValid,
  input  logic                           retireReady,
  output logic                           retireWrite,
  output logic [dpPkg::regAddrWidth-1:0] retireReg,
  output logic [dpPkg::dataWidth-1:0]    retireData,
  output logic [dpPkg::flagWidth-1:0]    retireFlags
);
  import dpPkg::*;

  logic                    stall;

  // Decode to register file and execute
  logic [regAddrWidth-1:0] rnAddr;
  logic [regAddrWidth-1:0] rmAddr;
  logic [dataWidth-1:0]    rnData;
  logic [dataWidth-1:0]    rmData;
  logic                    dValid;
  aluOpE                   aluOp;
  shiftOpE                 shiftOp;
  logic [shAmtWidth-1:0]   shAmt;
  logic                    useImm;
  logic [imm8Width-1:0]    imm8;
  logic [regAddrWidth-1:0] rd;
  logic [dataWidth-1:0]    rnOut;
  logic [dataWidth-1:0]    rmOut;
  logic [regAddrWidth-1:0] rnIdx;
  logic [regAddrWidth-1:0] rmIdx;

  // Execute to retire
  logic                    eValid;
  logic                    eWrite;
  logic [regAddrWidth-1:0] eReg;
  logic [dataWidth-1:0]    eData;
  logic [flagWidth-1:0]    eFlags;

  // Retire write port
  logic                    wrEn;
  logic [regAddrWidth-1:0] wrAddr;
  logic [dataWidth-1:0]    wrData;

  // ============================================================
  // Decode and register read
  // ============================================================
  decodeStage decode (
    .clk        (clk),
    .rstN       (rstN),
    .stall      (stall),
    .instrValid (instrValid),
    .instr      (instr),
    .instrReady (instrReady),
    .rnAddr     (rnAddr),
    .rmAddr     (rmAddr),
    .rnData     (rnData),
    .rmData     (rmData),
    .dValid     (dValid),
    .aluOp      (aluOp),
    .shiftOp    (shiftOp),
    .shAmt      (shAmt),
    .useImm     (useImm),
    .imm8       (imm8),
    .rd         (rd),
    .rnOut      (rnOut),
    .rmOut      (rmOut),
    .rnIdx      (rnIdx),
    .rmIdx      (rmIdx)
  );

  regFile rf (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (rnAddr),
    .rdAddrB (rmAddr),
    .rdDataA (rnData),
    .rdDataB (rmData),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData)
  );

  // ============================================================
  // Execute
  // ============================================================
  executeStage execute (
    .clk         (clk),
    .rstN        (rstN),
    .stall       (stall),
    .dValid      (dValid),
    .aluOp       (aluOp),
    .shiftOp     (shiftOp),
    .shAmt       (shAmt),
    .useImm      (useImm),
    .imm8        (imm8),
    .rd          (rd),
    .rnOut       (rnOut),
    .rmOut       (rmOut),
    .rnIdx       (rnIdx),
    .rmIdx       (rmIdx),
    .retireValid (retireValid),
    .retireWrite (retireWrite),
    .retireReg   (retireReg),
    .retireData  (retireData),
    .eValid      (eValid),
    .eWrite      (eWrite),
    .eReg        (eReg),
    .eData       (eData),
    .eFlags      (eFlags)
  );

  // ============================================================
  // Retire and register write
  // ============================================================
  retireStage retire (
    .clk         (clk),
    .rstN        (rstN),
    .eValid      (eValid),
    .eWrite      (eWrite),
    .eReg        (eReg),
    .eData       (eData),
    .eFlags      (eFlags),
    .retireReady (retireReady),
    .retireValid (retireValid),
    .retireWrite (retireWrite),
    .retireReg   (retireReg),
    .retireData  (retireData),
    .retireFlags (retireFlags),
    .stall       (stall),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData)
  );

endmodule

//--- verification/datapathProperties.sv
`timescale 1ns/100ps

module datapathProperties (
  input logic                           clk,
  input logic                           rstN,
  input logic                           instrReady,
  input logic                           retireValid,
  input logic                           retireReady,
  input logic                           retireWrite,
  input logic [dpPkg::regAddrWidth-1:0] retireReg,
  input logic [dpPkg::dataWidth-1:0]    retireData,
  input logic [dpPkg::flagWidth-1:0]    retireFlags
);
  import dpPkg::*;

  // ============================================================
  // Retire handshake
  // ============================================================
  // Held result keeps every field until taken
  retireStable: assert property (@(posedge clk) disable iff (!rstN)
    (retireValid && !retireReady) |=> (retireValid && $stable(retireWrite) &&
      $stable(retireReg) && $stable(retireData) && $stable(retireFlags)))
    else $error("retire fields changed while waiting for ready");

  // Input side stops exactly when retire is backed up
  readyFollowsStall: assert property (@(posedge clk) disable iff (!rstN)
    instrReady == !(retireValid && !retireReady))
    else $error("instrReady does not match back-pressure");

  // Pipeline comes out of reset empty
  emptyAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !retireValid)
    else $error("retireValid high right after reset");

endmodule

bind datapathTop datapathProperties props (
  .clk         (clk),
  .rstN        (rstN),
  .instrReady  (instrReady),
  .retireValid (retireValid),
  .retireReady (retireReady),
  .retireWrite (retireWrite),
  .retireReg   (retireReg),
  .retireData  (retireData),
  .retireFlags (retireFlags)
);

//--- verification/datapathTb.sv
`timescale 1ns/100ps

module datapathTb;
  import dpPkg::*;

  localparam int numRecs     = 20;
  localparam int recWords    = 5;
  localparam int resetCycles = 10;
  localparam int cycleLimit  = 20 * numRecs + resetCycles;
  localparam int drainCycles = 8;

  logic                    clk;
  logic                    rstN;
  logic                    instrValid;
  logic [dataWidth-1:0]    instr;
  logic                    instrReady;
  logic                    retireValid;
  logic                    retireReady;
  logic                    retireWrite;
  logic [regAddrWidth-1:0] retireReg;
  logic [dataWidth-1:0]    retireData;
  logic [flagWidth-1:0]    retireFlags;

  // Per record: instruction, write, reg, data, flags
  logic [31:0] stimMem [0:numRecs*recWords-1];

  integer seed;
  integer sendIdx;
  integer scoreIdx;
  integer cycles;
  integer base;
  logic   holding;

  datapathTop DUT (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instr       (instr),
    .instrReady  (instrReady),
    .retireValid (retireValid),
    .retireReady (retireReady),
    .retireWrite (retireWrite),
    .retireReg   (retireReg),
    .retireData  (retireData),
    .retireFlags (retireFlags)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkTimeout();
    cycles = cycles + 1;
    if (cycles > cycleLimit) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions retired",
               cycles, scoreIdx, numRecs);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // ============================================================
  // Stimulus and scoreboard
  // ============================================================
  initial begin
    seed        = 32'hba5c;
    sendIdx     = 0;
    scoreIdx    = 0;
    cycles      = 0;
    holding     = 1'b0;
    rstN        = 1'b0;
    instrValid  = 1'b0;
    instr       = '0;
    retireReady = 1'b1;
    $readmemh("verification/datapathStim.txt", stimMem);

    repeat (resetCycles) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    rstN = 1'b1;

    while (scoreIdx < numRecs) begin
      @(negedge clk);
      checkTimeout();

      // Output side, ready drops about one cycle in four
      retireReady = (($random(seed) & 3) != 0);

      // Input side, an offer not yet taken stays put
      if (!holding) begin
        if (sendIdx < numRecs && ($random(seed) & 3) != 0) begin
          instrValid = 1'b1;
          instr      = stimMem[sendIdx*recWords];
        end else begin
          instrValid = 1'b0;
        end
      end

      // Let instrReady follow the new retireReady
      #1;
      // Both handshakes complete at the next rising edge
      if (instrValid && instrReady) begin
        sendIdx = sendIdx + 1;
        holding = 1'b0;
      end else begin
        holding = instrValid;
      end

      if (retireValid && retireReady) begin
        base = scoreIdx * recWords;
        checkValue("retireWrite", {31'b0, retireWrite}, stimMem[base+1]);
        checkValue("retireReg", {28'b0, retireReg}, stimMem[base+2]);
        checkValue("retireData", retireData, stimMem[base+3]);
        checkValue("retireFlags", {28'b0, retireFlags}, stimMem[base+4]);
        scoreIdx = scoreIdx + 1;
      end
    end

    // Nothing may retire after the last record
    instrValid  = 1'b0;
    retireReady = 1'b1;
    repeat (drainCycles) begin
      @(negedge clk);
      checkValue("retireValid", {31'b0, retireValid}, 32'h0);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- all.f
verilog/dpPkg.sv
verilog/regFile.sv
verilog/barrelShifter.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/retireStage.sv
verilog/datapathTop.sv
verification/datapathProperties.sv
verification/datapathTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the fail message in the log
rm -rf obj_dir sim.log
verilator --binary --assert -f all.f --top-module datapathTb -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  && ! grep -q "TESTBENCH FAILED" sim.log \
  && echo "simulation run passed, see sim.log" \
  || { echo "simulation run failed, see sim.log"; exit 1; }

//--- verification/datapathStim.txt
// Columns: instruction word, retireWrite, retireReg, retireData, retireFlags (NZCV)
// Flags carry over from record to record in program order
3880007F 1 1 0000007F 0
29080080 1 2 FFFFFFFF 8
198800FF 1 3 00000080 0
7808007F 0 0 00000000 6
0A1000F0 1 4 000000F0 2
4A980001 1 5 00000081 2
6B000000 1 6 FFFFFFFF A
53832100 1 7 7FFFFFFF 2
3C380001 1 8 80000000 9
54845F00 1 9 FFFFFFFF 9
55031F00 1 A 80000000 B
15CD0000 1 B 7FFFFFFF 3
4602E400 1 C 10000008 1
5682E100 1 D 80000040 B
276E3C00 1 E 8000003F A
5F800000 1 F 00000000 6
70768000 0 0 FFFFFFFF 8
30888100 1 1 0000017D 0
31088000 1 2 000002FA 0
20108000 1 0 0000017D 2
